/* issue_queue_pkg.sv */
`default_nettype none

package issue_queue_pkg;

  ////////////////////
  // sizing

  parameter int MAX_ENTRIES = 16; // deepest queue the count type can describe

  ////////////////////
  // payload fields

  typedef logic [31:0] instr_t;  // raw instruction word
  typedef logic [31:0] pc_t;     // fetch pc of the instruction
  typedef logic [5:0]  rob_id_t; // reorder buffer tag

  // instr, pc and id packed msb first
  localparam int PAYLOAD_W = $bits(instr_t) + $bits(pc_t) + $bits(rob_id_t);

  typedef logic [PAYLOAD_W-1:0] iq_payload_t;

  ////////////////////
  // counts and ranks

  // one bit more than log2 so a full queue (count == MAX_ENTRIES) still fits
  typedef logic [$clog2(MAX_ENTRIES+1)-1:0] iq_cnt_t;

  // the rank of a slot is the number of valid slots older than it,
  // so rank 0 is the oldest entry and rank count-1 the youngest

endpackage

`default_nettype wire

/* iq_slot_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface iq_slot_if import issue_queue_pkg::*; ();

  ////////////////////
  // write side, from the allocator

  logic        wr_en;      // load this slot at the next edge
  iq_payload_t wr_payload; // packed instr, pc, id
  iq_cnt_t     wr_rank;    // age rank given to the new entry

  ////////////////////
  // slot state, registered inside iq_slot

  logic        valid;
  iq_payload_t payload;
  iq_cnt_t     rank;       // 0 = oldest

  ////////////////////
  // pop broadcast, same value on every slot

  iq_cnt_t     pop_amt;    // 0, 1 or 2 entries leave this cycle

  modport alloc (
    output wr_en, wr_payload, wr_rank,
    input  valid
  );

  modport slot (
    input  wr_en, wr_payload, wr_rank, pop_amt,
    output valid, payload, rank
  );

  modport sel (
    input  valid, payload, rank,
    output pop_amt
  );

endinterface

`default_nettype wire

/* iq_alloc.sv */
`timescale 1ns/10ps
`default_nettype none

module iq_alloc import issue_queue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic        push0,
  input  logic        push1,
  input  iq_payload_t push_payload0,
  input  iq_payload_t push_payload1,
  input  iq_cnt_t     pop_amt,       // entries leaving this cycle, from the selector
  iq_slot_if.alloc    slots [NUM_ENTRIES],
  output iq_cnt_t     free,
  output iq_cnt_t     count
);

  logic [NUM_ENTRIES-1:0] valid_vec;
  logic [NUM_ENTRIES-1:0] first_empty;  // one-hot, lowest empty slot
  logic [NUM_ENTRIES-1:0] second_empty; // one-hot, next empty slot above it
  logic [NUM_ENTRIES-1:0] wr_en_vec;
  logic [NUM_ENTRIES-1:0] sel_push0;    // slot takes push0 rather than push1

  logic    found0;
  logic    found1;
  logic    acc0;      // push0 accepted
  logic    acc1;      // push1 accepted
  iq_cnt_t base_rank; // rank of the oldest new entry
  iq_cnt_t rank0;
  iq_cnt_t rank1;

  ////////////////////
  // occupancy

  always_comb begin
    count = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      count = count + iq_cnt_t'(valid_vec[i]);
    end
  end

  assign free = iq_cnt_t'(NUM_ENTRIES) - count; // only slots empty before the edge

  ////////////////////
  // pick the two lowest empty slots

  always_comb begin
    found0       = 1'b0;
    found1       = 1'b0;
    first_empty  = '0;
    second_empty = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!valid_vec[i]) begin
        if (!found0) begin
          found0         = 1'b1;
          first_empty[i] = 1'b1;
        end else if (!found1) begin
          found1          = 1'b1;
          second_empty[i] = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // acceptance and ranks

  assign acc0 = push0 && (free >= iq_cnt_t'(1));
  // push1 needs its own slot on top of push0's when both are up
  assign acc1 = push1 && (push0 ? (free >= iq_cnt_t'(2)) : (free >= iq_cnt_t'(1)));

  // survivors of this cycle's pop keep ranks 0 .. count-pop_amt-1
  assign base_rank = count - pop_amt;
  assign rank0     = base_rank;
  assign rank1     = acc0 ? base_rank + iq_cnt_t'(1) : base_rank; // push1 is younger

  // push0 goes to the lowest empty slot, push1 to the next one,
  // or to the lowest when push0 is not taken
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      sel_push0[i] = acc0 && first_empty[i];
      wr_en_vec[i] = sel_push0[i]
                   | (acc1 && (acc0 ? second_empty[i] : first_empty[i]));
    end
  end

  ////////////////////
  // per-slot hookup

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_slot
    assign valid_vec[g]        = slots[g].valid;
    assign slots[g].wr_en      = wr_en_vec[g];
    assign slots[g].wr_payload = sel_push0[g] ? push_payload0 : push_payload1;
    assign slots[g].wr_rank    = sel_push0[g] ? rank0 : rank1;
  end

endmodule

`default_nettype wire

/* iq_slot.sv */
`timescale 1ns/10ps
`default_nettype none

module iq_slot import issue_queue_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   flush,
  iq_slot_if.slot port
);

  logic        valid_q;
  iq_payload_t payload_q;
  iq_cnt_t     rank_q;

  logic popped;  // this entry is among the ones leaving
  logic aging;   // older entries leave, this one moves up

  ////////////////////
  // pop decode

  // pop_amt covers ranks 0 .. pop_amt-1
  assign popped = valid_q && (rank_q < port.pop_amt);
  assign aging  = valid_q && !popped && (port.pop_amt != '0);

  ////////////////////
  // valid bit

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid_q <= 1'b0;              // flush beats a same-cycle write
    end else begin
      if (port.wr_en) begin
        valid_q <= 1'b1;            // allocator only writes empty slots
      end else if (popped) begin
        valid_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // payload and rank

  always_ff @(posedge clk) begin
    if (port.wr_en) begin
      payload_q <= port.wr_payload;
      rank_q    <= port.wr_rank;
    end else if (aging) begin
      rank_q <= rank_q - port.pop_amt; // stays dense, 0 is still the oldest
    end
  end

  ////////////////////
  // outputs

  assign port.valid   = valid_q;
  assign port.payload = payload_q;
  assign port.rank    = rank_q;    // only meaningful while valid

endmodule

`default_nettype wire

/* iq_select.sv */
`timescale 1ns/10ps
`default_nettype none

module iq_select import issue_queue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic    pop0,
  input  logic    pop1,
  iq_slot_if.sel  slots [NUM_ENTRIES],
  output logic    pop_valid0,
  output logic    pop_valid1,
  output instr_t  pop_instr0,
  output instr_t  pop_instr1,
  output pc_t     pop_pc0,
  output pc_t     pop_pc1,
  output rob_id_t pop_id0,
  output rob_id_t pop_id1
);

  logic        valid_vec [NUM_ENTRIES];
  iq_cnt_t     rank_vec  [NUM_ENTRIES];
  iq_payload_t data_vec  [NUM_ENTRIES];

  logic [NUM_ENTRIES-1:0] hit0; // one-hot, slot holding rank 0
  logic [NUM_ENTRIES-1:0] hit1; // one-hot, slot holding rank 1

  iq_payload_t out0;
  iq_payload_t out1;
  iq_cnt_t     pop_amt;

  ////////////////////
  // gather slot state

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_slot
    assign valid_vec[g]     = slots[g].valid;
    assign rank_vec[g]      = slots[g].rank;
    assign data_vec[g]      = slots[g].payload;
    assign slots[g].pop_amt = pop_amt;        // same amount to every slot
  end

  ////////////////////
  // rank match

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      hit0[i] = valid_vec[i] && (rank_vec[i] == iq_cnt_t'(0));
      hit1[i] = valid_vec[i] && (rank_vec[i] == iq_cnt_t'(1));
    end
  end

  // ranks are unique among valid slots, so an and-or mux is enough
  always_comb begin
    out0 = '0;
    out1 = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (hit0[i]) begin
        out0 = out0 | data_vec[i];
      end
      if (hit1[i]) begin
        out1 = out1 | data_vec[i];
      end
    end
  end

  ////////////////////
  // pop outputs

  assign pop_valid0 = |hit0; // count >= 1
  assign pop_valid1 = |hit1; // count >= 2

  assign {pop_instr0, pop_pc0, pop_id0} = out0;
  assign {pop_instr1, pop_pc1, pop_id1} = out1;

  ////////////////////
  // pop amount

  // pop1 only counts behind pop0, and only for entries that exist
  always_comb begin
    pop_amt = '0;
    if (pop0 && pop_valid0) begin
      if (pop1 && pop_valid1) begin
        pop_amt = iq_cnt_t'(2);
      end else begin
        pop_amt = iq_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* issue_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_queue import issue_queue_pkg::*; #(
  parameter int NUM_ENTRIES = 8 // up to MAX_ENTRIES
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    flush,

  // push port 0, older of the two
  input  logic    push0,
  input  instr_t  push_instr0,
  input  pc_t     push_pc0,
  input  rob_id_t push_id0,

  // push port 1
  input  logic    push1,
  input  instr_t  push_instr1,
  input  pc_t     push_pc1,
  input  rob_id_t push_id1,

  // pop side
  input  logic    pop0,
  input  logic    pop1,
  output logic    pop_valid0,
  output logic    pop_valid1,
  output instr_t  pop_instr0,
  output instr_t  pop_instr1,
  output pc_t     pop_pc0,
  output pc_t     pop_pc1,
  output rob_id_t pop_id0,
  output rob_id_t pop_id1,

  output iq_cnt_t free,
  output iq_cnt_t count
);

  iq_payload_t push_payload0;
  iq_payload_t push_payload1;
  iq_cnt_t     pop_amt;

  iq_slot_if slot_if [NUM_ENTRIES] ();

  ////////////////////
  // push packing

  assign push_payload0 = {push_instr0, push_pc0, push_id0};
  assign push_payload1 = {push_instr1, push_pc1, push_id1};

  assign pop_amt = slot_if[0].pop_amt; // broadcast copy, all slots see the same

  ////////////////////
  // allocator

  iq_alloc #(
    .NUM_ENTRIES   (NUM_ENTRIES)
  ) iq_alloc_i (
    .push0         (push0),
    .push1         (push1),
    .push_payload0 (push_payload0),
    .push_payload1 (push_payload1),
    .pop_amt       (pop_amt),
    .slots         (slot_if),
    .free          (free),
    .count         (count)
  );

  ////////////////////
  // slot array

  for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_slot
    iq_slot iq_slot_i (
      .clk   (clk),
      .reset (reset),
      .flush (flush),
      .port  (slot_if[g])
    );
  end

  ////////////////////
  // oldest-first select

  iq_select #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) iq_select_i (
    .pop0        (pop0),
    .pop1        (pop1),
    .slots       (slot_if),
    .pop_valid0  (pop_valid0),
    .pop_valid1  (pop_valid1),
    .pop_instr0  (pop_instr0),
    .pop_instr1  (pop_instr1),
    .pop_pc0     (pop_pc0),
    .pop_pc1     (pop_pc1),
    .pop_id0     (pop_id0),
    .pop_id1     (pop_id1)
  );

endmodule

`default_nettype wire

/* issue_queue_props.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_queue_props import issue_queue_pkg::*; #(
  parameter int NUM_ENTRIES = 8
) (
  input logic    clk,
  input logic    reset,
  input logic    flush,
  input logic    pop_valid0,
  input logic    pop_valid1,
  input iq_cnt_t count,
  input iq_cnt_t free
);

  ////////////////////
  // occupancy

  // every slot is either valid or free, never both
  a_count_plus_free: assert property (
    @(posedge clk) disable iff (reset)
      (int'(count) + int'(free)) == NUM_ENTRIES
  ) else $error("count %0d plus free %0d is not %0d", count, free, NUM_ENTRIES);

  ////////////////////
  // pop side

  // second oldest only exists behind the oldest
  a_pop_valid_order: assert property (
    @(posedge clk) disable iff (reset)
      pop_valid1 |-> pop_valid0
  ) else $error("pop_valid1 high while pop_valid0 low");

  ////////////////////
  // flush

  a_flush_empties: assert property (
    @(posedge clk) disable iff (reset)
      flush |=> (count == '0)    // pushes in the flush cycle are dropped too
  ) else $error("count is %0d the cycle after a flush", count);

endmodule

bind issue_queue issue_queue_props #(
  .NUM_ENTRIES (NUM_ENTRIES)
) issue_queue_props_i (
  .clk        (clk),
  .reset      (reset),
  .flush      (flush),
  .pop_valid0 (pop_valid0),
  .pop_valid1 (pop_valid1),
  .count      (count),
  .free       (free)
);

`default_nettype wire

/* issue_queue_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_queue_tb import issue_queue_pkg::*; ();

  localparam int NUM_ENTRIES = 8;
  localparam int NUM_ROWS    = 16;
  localparam int NUM_IDS     = 12;
  localparam int RESET_WAIT  = 10;   // cycles the queue may take to settle after reset
  localparam int RUN_LIMIT   = 1000; // watchdog for the whole run

  logic    clk;
  logic    reset;
  logic    flush;
  logic    push0;
  logic    push1;
  instr_t  push_instr0;
  instr_t  push_instr1;
  pc_t     push_pc0;
  pc_t     push_pc1;
  rob_id_t push_id0;
  rob_id_t push_id1;
  logic    pop0;
  logic    pop1;
  logic    pop_valid0;
  logic    pop_valid1;
  instr_t  pop_instr0;
  instr_t  pop_instr1;
  pc_t     pop_pc0;
  pc_t     pop_pc1;
  rob_id_t pop_id0;
  rob_id_t pop_id1;
  iq_cnt_t free;
  iq_cnt_t count;

  ////////////////////
  // stimulus and expectation table

  string   row_name  [NUM_ROWS];
  logic    row_push0 [NUM_ROWS];
  logic    row_push1 [NUM_ROWS];
  rob_id_t row_id0   [NUM_ROWS]; // ids pushed on port 0 / 1
  rob_id_t row_id1   [NUM_ROWS];
  logic    row_pop0  [NUM_ROWS];
  logic    row_pop1  [NUM_ROWS];
  logic    row_flush [NUM_ROWS];
  int      row_count [NUM_ROWS]; // expected state after the row's edge
  int      row_free  [NUM_ROWS];
  logic    row_pv0   [NUM_ROWS];
  logic    row_pv1   [NUM_ROWS];
  rob_id_t row_exp0  [NUM_ROWS]; // oldest id, only checked when row_pv0
  rob_id_t row_exp1  [NUM_ROWS]; // second oldest, only when row_pv1

  rob_id_t ids [NUM_IDS]; // distinct random reorder ids
  int      seed;
  int      errors;
  int      n_rows;
  logic    timed_out;

  issue_queue #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) issue_queue_i (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .push0       (push0),
    .push_instr0 (push_instr0),
    .push_pc0    (push_pc0),
    .push_id0    (push_id0),
    .push1       (push1),
    .push_instr1 (push_instr1),
    .push_pc1    (push_pc1),
    .push_id1    (push_id1),
    .pop0        (pop0),
    .pop1        (pop1),
    .pop_valid0  (pop_valid0),
    .pop_valid1  (pop_valid1),
    .pop_instr0  (pop_instr0),
    .pop_instr1  (pop_instr1),
    .pop_pc0     (pop_pc0),
    .pop_pc1     (pop_pc1),
    .pop_id0     (pop_id0),
    .pop_id1     (pop_id1),
    .free        (free),
    .count       (count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  // payload fields tied to the id so the pc can be predicted at the pop side
  function automatic pc_t pc_for(input rob_id_t id);
    return 32'h0000_1000 + {24'h0, id, 2'b00};
  endfunction

  function automatic instr_t instr_for(input rob_id_t id);
    return 32'h0000_0013 | {19'h0, id, 7'h0}; // addi-like word, id in rd bits
  endfunction

  task automatic add_row(input string name, input logic p0, input logic p1,
                         input rob_id_t i0, input rob_id_t i1,
                         input logic q0, input logic q1, input logic fl,
                         input int cnt, input int fr, input logic v0, input logic v1,
                         input rob_id_t e0, input rob_id_t e1);
    row_name[n_rows]  = name;
    row_push0[n_rows] = p0;
    row_push1[n_rows] = p1;
    row_id0[n_rows]   = i0;
    row_id1[n_rows]   = i1;
    row_pop0[n_rows]  = q0;
    row_pop1[n_rows]  = q1;
    row_flush[n_rows] = fl;
    row_count[n_rows] = cnt;
    row_free[n_rows]  = fr;
    row_pv0[n_rows]   = v0;
    row_pv1[n_rows]   = v1;
    row_exp0[n_rows]  = e0;
    row_exp1[n_rows]  = e1;
    n_rows++;
  endtask

  task automatic build_ids();
    logic dup;
    for (int k = 0; k < NUM_IDS; k++) begin
      dup = 1'b1;
      while (dup) begin                      // redraw until unique
        ids[k] = rob_id_t'($random(seed));
        dup    = 1'b0;
        for (int j = 0; j < k; j++) begin
          if (ids[j] == ids[k]) begin
            dup = 1'b1;
          end
        end
      end
    end
  endtask

  ////////////////////
  // rows: name, push0 push1 id0 id1, pop0 pop1 flush, count free pv0 pv1 exp0 exp1

  task automatic build_table();
    add_row("after_reset",    0, 0, 0, 0,           0, 0, 0, 0, 8, 0, 0, 0, 0);
    add_row("push_pair_a",    1, 1, ids[0], ids[1], 0, 0, 0, 2, 6, 1, 1, ids[0], ids[1]);
    add_row("push_pair_b",    1, 1, ids[2], ids[3], 0, 0, 0, 4, 4, 1, 1, ids[0], ids[1]);
    add_row("push0_only",     1, 0, ids[4], 0,      0, 0, 0, 5, 3, 1, 1, ids[0], ids[1]);
    add_row("push1_only",     0, 1, 0, ids[5],      0, 0, 0, 6, 2, 1, 1, ids[0], ids[1]);
    add_row("fill",           1, 1, ids[6], ids[7], 0, 0, 0, 8, 0, 1, 1, ids[0], ids[1]);
    add_row("push_when_full", 1, 1, ids[8], ids[9], 0, 0, 0, 8, 0, 1, 1, ids[0], ids[1]);
    add_row("pop1_alone",     0, 0, 0, 0,           0, 1, 0, 8, 0, 1, 1, ids[0], ids[1]);
    add_row("pop_two",        0, 0, 0, 0,           1, 1, 0, 6, 2, 1, 1, ids[2], ids[3]);
    // two in, two out, queue stays at six
    add_row("push_pop_two",   1, 1, ids[10], ids[11], 1, 1, 0, 6, 2, 1, 1, ids[4], ids[5]);
    add_row("pop_one",        0, 0, 0, 0,           1, 0, 0, 5, 3, 1, 1, ids[5], ids[6]);
    add_row("pop_two_again",  0, 0, 0, 0,           1, 1, 0, 3, 5, 1, 1, ids[7], ids[10]);
    add_row("flush_w_push",   1, 1, ids[8], ids[9], 0, 0, 1, 0, 8, 0, 0, 0, 0);
    add_row("push_after_fl",  1, 1, ids[8], ids[9], 0, 0, 0, 2, 6, 1, 1, ids[8], ids[9]);
    add_row("drain",          0, 0, 0, 0,           1, 1, 0, 0, 8, 0, 0, 0, 0);
    add_row("pop_on_empty",   0, 0, 0, 0,           1, 1, 0, 0, 8, 0, 0, 0, 0);
  endtask

  task automatic compare_field(input int r, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %0d actual %0d", row_name[r], field, exp, act);
      errors++;
    end
  endtask

  task automatic check_row(input int r);
    compare_field(r, "count", row_count[r], count);
    compare_field(r, "free", row_free[r], free);
    compare_field(r, "pop_valid0", row_pv0[r], pop_valid0);
    compare_field(r, "pop_valid1", row_pv1[r], pop_valid1);
    if (row_pv0[r]) begin
      compare_field(r, "pop_id0", row_exp0[r], pop_id0);
      compare_field(r, "pop_pc0", pc_for(row_exp0[r]), pop_pc0); // payload travels intact
      compare_field(r, "pop_instr0", instr_for(row_exp0[r]), pop_instr0);
    end
    if (row_pv1[r]) begin
      compare_field(r, "pop_id1", row_exp1[r], pop_id1);
      compare_field(r, "pop_pc1", pc_for(row_exp1[r]), pop_pc1);
      compare_field(r, "pop_instr1", instr_for(row_exp1[r]), pop_instr1);
    end
  endtask

  task automatic drive_idle();
    push0 <= 1'b0;
    push1 <= 1'b0;
    pop0  <= 1'b0;
    pop1  <= 1'b0;
    flush <= 1'b0;
  endtask

  // row goes in at one edge, is taken at the next, checked mid-cycle after it
  task automatic apply_row(input int r);
    @(posedge clk);
    push0       <= row_push0[r];
    push1       <= row_push1[r];
    push_id0    <= row_id0[r];
    push_id1    <= row_id1[r];
    push_pc0    <= pc_for(row_id0[r]);
    push_pc1    <= pc_for(row_id1[r]);
    push_instr0 <= instr_for(row_id0[r]);
    push_instr1 <= instr_for(row_id1[r]);
    pop0        <= row_pop0[r];
    pop1        <= row_pop1[r];
    flush       <= row_flush[r];
    @(posedge clk);
    drive_idle();                   // no pops, so entries hold in place
    @(negedge clk);
    check_row(r);
  endtask

  task automatic wait_reset_state();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(free == iq_cnt_t'(NUM_ENTRIES) && count == '0) && waited < RESET_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!(free == iq_cnt_t'(NUM_ENTRIES) && count == '0)) begin
      $display("timeout: queue did not reach an empty state after reset");
      errors++;
      timed_out = 1'b1;
    end
  endtask

  ////////////////////
  // main sequence

  initial begin
    seed        = 32'h3ff3;
    errors      = 0;
    n_rows      = 0;
    timed_out   = 1'b0;
    reset       = 1'b1;
    flush       = 1'b0;
    push0       = 1'b0;
    push1       = 1'b0;
    push_instr0 = '0;
    push_instr1 = '0;
    push_pc0    = '0;
    push_pc1    = '0;
    push_id0    = '0;
    push_id1    = '0;
    pop0        = 1'b0;
    pop1        = 1'b0;
    build_ids();
    build_table();                  // ids land in the table before any row runs
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    wait_reset_state();
    if (!timed_out) begin
      for (int r = 0; r < n_rows; r++) begin
        apply_row(r);
      end
    end
    $display("rows applied: %0d, errors: %0d", n_rows, errors);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (RUN_LIMIT) @(posedge clk);  // whole-run watchdog
    $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* issue_queue.f */
issue_queue_pkg.sv
iq_slot_if.sv
iq_alloc.sv
iq_slot.sv
iq_select.sv
issue_queue.sv
issue_queue_props.sv
issue_queue_tb.sv
